//--- Makefile
# Verilator build and run of the pipeline controller testbench

VERILATOR ?= verilator
TOP       ?= tb_slurm_pipe
FILELIST  ?= slurm_pipe_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
STIMULUS  ?= dv/pipe_stimulus.txt
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) $(STIMULUS)
	./$(BIN) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/pipe_stimulus.txt
# name v insn addr_in h1 h2 h3 br br_addr halt wake | req addr nop2 nop4 stage4 pc4
# hex fields; x = don't check; expected values are after the edge that follows the inputs
reset_flow    1 00000000 000 0 0 0 0 00000000 0 0 1 000 1 1 x x
reset_flow    1 C0DE0000 000 0 0 0 0 00000000 0 0 1 001 1 1 x x
reset_flow    1 C0DE0001 001 0 0 0 0 00000000 0 0 1 002 1 1 x x
reset_flow    1 C0DE0002 002 0 0 0 0 00000000 0 0 1 003 0 1 x x
reset_flow    1 C0DE0003 003 0 0 0 0 00000000 0 0 1 004 0 1 x x
reset_flow    1 C0DE0004 004 0 0 0 0 00000000 0 0 1 005 0 0 C0DE0000 00000000
reset_flow    1 C0DE0005 005 0 0 0 0 00000000 0 0 1 006 0 0 C0DE0001 00000004
reset_flow    1 C0DE0006 006 0 0 0 0 00000000 0 0 1 007 0 0 C0DE0002 00000008
branch        1 C0DE0007 007 0 0 0 1 00000100 0 0 1 040 0 0 C0DE0003 0000000C
branch        1 C0DE0040 040 0 0 0 0 00000000 0 0 1 041 1 0 C0DE0004 00000010
branch        1 C0DE0041 041 0 0 0 0 00000000 0 0 1 042 1 0 C0DE0005 00000014
branch        1 C0DE0042 042 0 0 0 0 00000000 0 0 1 043 0 1 x x
branch        1 C0DE0043 043 0 0 0 0 00000000 0 0 1 044 0 1 x x
branch        1 C0DE0044 044 0 0 0 0 00000000 0 0 1 045 0 0 C0DE0040 00000100
branch        1 C0DE0045 045 0 0 0 0 00000000 0 0 1 046 0 0 C0DE0041 00000104
hazard_stalls 1 C0DE0046 046 1 0 0 0 00000000 0 0 1 047 0 0 C0DE0042 00000108
hazard_stalls 1 C0DE0047 047 0 0 0 0 00000000 0 0 1 046 1 0 C0DE0043 0000010C
hazard_stalls 1 C0DE0046 046 0 0 0 0 00000000 0 0 1 046 1 0 C0DE0044 00000110
hazard_stalls 1 C0DE0046 046 0 0 0 0 00000000 0 0 1 046 1 1 x x
hazard_stalls 1 C0DE0046 046 0 0 0 0 00000000 0 0 1 047 0 1 x x
hazard_stalls 1 C0DE0047 047 0 0 0 0 00000000 0 0 1 048 1 1 x x
hazard_stalls 1 C0DE0048 048 0 0 0 0 00000000 0 0 1 049 0 0 C0DE0045 00000114
hazard_stalls 1 C0DE0049 049 0 0 0 0 00000000 0 0 1 04A 0 1 x x
hazard_stalls 1 C0DE004A 04A 0 0 0 0 00000000 0 0 1 04B 0 0 C0DE0046 00000118
hazard_stalls 1 C0DE004B 04B 0 1 0 0 00000000 0 0 1 04C 0 0 C0DE0047 0000011C
hazard_stalls 1 C0DE004C 04C 0 0 0 0 00000000 0 0 1 04B 1 0 C0DE0048 00000120
hazard_stalls 1 C0DE004B 04B 0 0 0 0 00000000 0 0 1 04B 1 0 C0DE0049 00000124
hazard_stalls 1 C0DE004B 04B 0 0 0 0 00000000 0 0 1 04C 0 1 x x
hazard_stalls 1 C0DE004C 04C 0 0 0 0 00000000 0 0 1 04D 1 1 x x
hazard_stalls 1 C0DE004D 04D 0 0 0 0 00000000 0 0 1 04E 0 0 C0DE004A 00000128
hazard_stalls 1 C0DE004E 04E 0 0 1 0 00000000 0 0 1 04F 0 1 x x
hazard_stalls 1 C0DE004F 04F 0 0 0 0 00000000 0 0 1 04E 1 0 C0DE004B 0000012C
hazard_stalls 1 C0DE004E 04E 0 0 0 0 00000000 0 0 1 04F 0 0 C0DE004C 00000130
hazard_stalls 1 C0DE004F 04F 0 0 0 0 00000000 0 0 1 050 1 1 x x
hazard_stalls 1 C0DE0050 050 0 0 0 0 00000000 0 0 1 051 0 0 C0DE004D 00000134
miss_rewind   0 00000000 000 0 0 0 0 00000000 0 0 1 052 0 1 x x
miss_rewind   0 00000000 000 0 0 0 0 00000000 0 0 1 051 0 0 C0DE004E 00000138
miss_rewind   0 00000000 000 0 0 0 0 00000000 0 0 1 051 1 0 C0DE004F 0000013C
miss_rewind   1 C0DE0051 051 0 0 0 0 00000000 0 0 1 051 1 0 C0DE0050 00000140
miss_rewind   1 C0DE0051 051 0 0 0 0 00000000 0 0 1 052 1 1 x x
miss_rewind   1 C0DE0052 052 0 0 0 0 00000000 0 0 1 053 1 1 x x
miss_rewind   1 C0DE0053 053 0 0 0 0 00000000 0 0 1 054 0 1 x x
miss_rewind   1 C0DE0054 054 0 0 0 0 00000000 0 0 1 055 0 1 x x
miss_rewind   1 C0DE0055 055 0 0 0 0 00000000 0 0 1 056 0 0 C0DE0051 00000144
halt_wake     1 C0DE0056 056 0 0 0 0 00000000 1 0 1 057 0 0 C0DE0052 00000148
halt_wake     1 C0DE0057 057 0 0 0 0 00000000 0 0 0 058 0 0 C0DE0053 0000014C
halt_wake     1 00000000 000 0 0 0 1 00000200 0 0 0 080 1 0 C0DE0054 00000150
halt_wake     1 00000000 000 0 0 0 0 00000000 0 1 1 080 1 0 C0DE0055 00000154
halt_wake     1 C0DE0080 080 0 0 0 0 00000000 0 0 1 081 1 1 x x
halt_wake     1 C0DE0081 081 0 0 0 0 00000000 0 0 1 082 1 1 x x
halt_wake     1 C0DE0082 082 0 0 0 0 00000000 0 0 1 083 0 1 x x
halt_wake     1 C0DE0083 083 0 0 0 0 00000000 0 0 1 084 0 1 x x
halt_wake     1 C0DE0084 084 0 0 0 0 00000000 0 0 1 085 0 0 C0DE0080 00000200

//--- dv/tb_slurm_pipe.sv
// ==========================================================================
// Vector replay for the pipeline controller, read from dv/pipe_stimulus.txt.
// Inputs change on the falling edge, outputs are checked 10 ns after rising.
// ==========================================================================
module tb_slurm_pipe
	import slurm_pipe_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_VEC      = 256;
	localparam int RESET_CYCLES = 10;
	localparam int MARGIN       = 20;
	localparam int NF           = 16;	// Fields after the test name

	logic       CLK;
	logic       RSTb;
	logic       instruction_valid;
	insn_t      instruction_in;
	word_addr_t instruction_address_in;
	logic       hazard_1, hazard_2, hazard_3;
	reg_tag_t   hazard_reg0;
	logic       modifies_flags0;
	logic       halt_request, wake;
	logic       load_pc_request;
	byte_addr_t load_pc_address;

	logic       instruction_request;
	word_addr_t instruction_address;
	insn_t      pipeline_stage_0, pipeline_stage_1, pipeline_stage_2, pipeline_stage_3;
	insn_t      pipeline_stage_4;
	byte_addr_t pc_stage_4;
	logic       nop_stage_2, nop_stage_4;
	reg_tag_t   hazard_reg1, hazard_reg2, hazard_reg3;
	logic       modifies_flags1, modifies_flags2, modifies_flags3;

	string       names [MAX_VEC];
	logic [31:0] fld [MAX_VEC][NF];
	bit          care [MAX_VEC][NF];	// Cleared where the file says x
	int          n_vec      = 0;
	int          limit      = 0;
	int          cycles     = 0;
	int          test_errs  = 0;
	int          pass_tests = 0;
	int          fail_tests = 0;

	slurm_pipe_top dut_i (.*);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;	// 40 ns period

	// Run limit from the vector count
	always @(posedge CLK) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: the replay did not finish within %0d cycles", limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Hazard tag and flag bit given to each word from its low bits
	function automatic reg_tag_t tag_of(insn_t word);
		return word[REG_TAG_W-1:0];
	endfunction

	function automatic logic flag_of(insn_t word);
		return word[0];
	endfunction

	task automatic load_vectors();
		int    fd;
		int    cnt;
		string line;
		string tok [NF+1];
		fd = $fopen("dv/pipe_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file dv/pipe_stimulus.txt");
		end else begin
			while (!$feof(fd) && n_vec < MAX_VEC) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() == 0 || line.getc(0) == 8'h23)
					continue;	// Blank or comment
				cnt = $sscanf(line, "%s %s %s %s %s %s %s %s %s %s %s %s %s %s %s %s %s",
					tok[0], tok[1], tok[2], tok[3], tok[4], tok[5], tok[6], tok[7],
					tok[8], tok[9], tok[10], tok[11], tok[12], tok[13], tok[14],
					tok[15], tok[16]);
				if (cnt != NF + 1)
					continue;
				names[n_vec] = tok[0];
				for (int f = 0; f < NF; f++) begin
					care[n_vec][f] = (tok[f+1] != "x");
					fld[n_vec][f]  = '0;
					if (care[n_vec][f])
						void'($sscanf(tok[f+1], "%h", fld[n_vec][f]));
				end
				n_vec++;
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_line(int i);
		instruction_valid      = fld[i][0][0];
		instruction_in         = fld[i][1];
		instruction_address_in = fld[i][2][WORD_ADDR_W-1:0];
		hazard_1               = fld[i][3][0];
		hazard_2               = fld[i][4][0];
		hazard_3               = fld[i][5][0];
		hazard_reg0            = tag_of(pipeline_stage_0);	// Tags of the word now in fetch
		modifies_flags0        = flag_of(pipeline_stage_0);
		load_pc_request        = fld[i][6][0];
		load_pc_address        = fld[i][7];
		halt_request           = fld[i][8][0];
		wake                   = fld[i][9][0];
	endtask

	task automatic check_value(string test, string what, logic [31:0] exp, logic [31:0] act);
		assert (act === exp) else begin
			$display("** Error: test %s, %s expected %h actual %h", test, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_line(int i);
		logic [31:0] act [NF];
		string       what [NF];
		act[10] = {31'b0, instruction_request};
		act[11] = {2'b0, instruction_address};
		act[12] = {31'b0, nop_stage_2};
		act[13] = {31'b0, nop_stage_4};
		act[14] = pipeline_stage_4;
		act[15] = pc_stage_4;
		what[10] = "instruction_request";
		what[11] = "instruction_address";
		what[12] = "nop_stage_2";
		what[13] = "nop_stage_4";
		what[14] = "pipeline_stage_4";
		what[15] = "pc_stage_4";
		for (int f = 10; f < NF; f++)
			if (care[i][f])
				check_value(names[i], what[f], fld[i][f], act[f]);
		check_value(names[i], "pipeline_stage_0", fld[i][1], pipeline_stage_0);	// Word fetched
		// Slots past decode shift every edge and reach stage 4 in turn
		if (i + 1 < n_vec && care[i+1][14])
			check_value(names[i], "pipeline_stage_3", fld[i+1][14], pipeline_stage_3);
		if (i + 2 < n_vec && care[i+2][14])
			check_value(names[i], "pipeline_stage_2", fld[i+2][14], pipeline_stage_2);
		if (i + 3 < n_vec && care[i+3][14])
			check_value(names[i], "pipeline_stage_1", fld[i+3][14], pipeline_stage_1);
		// Tags stay with their word through a decode hold
		check_value(names[i], "hazard_reg1", {24'b0, tag_of(pipeline_stage_1)},
			{24'b0, hazard_reg1});
		check_value(names[i], "hazard_reg2", {24'b0, tag_of(pipeline_stage_2)},
			{24'b0, hazard_reg2});
		check_value(names[i], "hazard_reg3", {24'b0, tag_of(pipeline_stage_3)},
			{24'b0, hazard_reg3});
		check_value(names[i], "modifies_flags1", {31'b0, flag_of(pipeline_stage_1)},
			{31'b0, modifies_flags1});
		check_value(names[i], "modifies_flags2", {31'b0, flag_of(pipeline_stage_2)},
			{31'b0, modifies_flags2});
		check_value(names[i], "modifies_flags3", {31'b0, flag_of(pipeline_stage_3)},
			{31'b0, modifies_flags3});
	endtask

	task automatic report_test(string test);
		if (test_errs == 0) begin
			pass_tests++;
			$display("Test %s passed", test);
		end else begin
			fail_tests++;
			$display("Test %s failed with %0d errors", test, test_errs);
		end
		test_errs = 0;
	endtask

	task automatic replay_vectors();
		int i;
		for (i = 0; i < n_vec; i++) begin
			@(negedge CLK);
			RSTb = 1'b1;	// First vector runs with reset released
			drive_line(i);
			@(posedge CLK);
			#10;
			check_line(i);
			if (i == n_vec - 1 || names[i+1] != names[i])
				report_test(names[i]);	// Last line of this test
		end
	endtask

	initial begin
		RSTb                   = 1'b0;
		instruction_valid      = 1'b0;
		instruction_in         = '0;
		instruction_address_in = '0;
		hazard_1               = 1'b0;
		hazard_2               = 1'b0;
		hazard_3               = 1'b0;
		hazard_reg0            = '0;
		modifies_flags0        = 1'b0;
		halt_request           = 1'b0;
		wake                   = 1'b0;
		load_pc_request        = 1'b0;
		load_pc_address        = '0;
		load_vectors();
		limit = n_vec + RESET_CYCLES + MARGIN;
		repeat (RESET_CYCLES) @(posedge CLK);
		if (n_vec == 0) begin
			$display("No vectors could be read, nothing was tested");
			fail_tests++;
		end else begin
			replay_vectors();
		end
		$display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
		if (fail_tests == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- hw/pc_unit.sv
// ==========================================================================
// Fetch PC and previous PC, word addressed. Clearing comes only from
// PC_CLEAR, so the sequencer must sit in reset for at least one edge.
// ==========================================================================
module pc_unit
	import slurm_pipe_pkg::*;
(
	input  logic       CLK,
	input  pc_op_t     pc_op,
	input  word_addr_t target,	// Branch target, word address
	output word_addr_t pc
);

	word_addr_t prev_pc;	// Address issued one fetch earlier

	always_ff @(posedge CLK) begin
		case (pc_op)
			PC_CLEAR: begin
				pc      <= '0;
				prev_pc <= '0;
			end
			PC_STEP: begin
				prev_pc <= pc;
				pc      <= pc + word_addr_t'(1);
			end
			PC_LOAD: begin
				prev_pc <= pc;	// Keeps the last issued address for a rewind
				pc      <= target;
			end
			PC_REWIND: begin
				pc <= prev_pc;	// prev stays, repeated rewinds land in the same place
			end
			default: begin
				pc      <= pc;	// PC_HOLD
				prev_pc <= prev_pc;
			end
		endcase
	end

	// Rewind restores the address from before the last step
	a_rewind: assert property (@(posedge CLK)
		(pc_op == PC_REWIND) |=> (pc == $past(prev_pc)));

endmodule

//--- hw/pipe_ctrl_if.sv
// ==========================================================================
// Per-slot hold and kill controls from the sequencer to the stage registers.
// All controls are active high and combinational from the sequencer state.
// ==========================================================================
interface pipe_ctrl_if
	import slurm_pipe_pkg::*;
();

	logic fetch_kill;	// Fetch slot loads a bubble
	logic decode_hold;	// Decode slot keeps its contents
	logic decode_kill;	// Decode bubble bit set
	logic execute_kill;	// Execute slot loads a bubble
	logic tail_kill;	// Memory and writeback slots load bubbles

	modport seq (
		output fetch_kill, decode_hold, decode_kill,
		output execute_kill, tail_kill
	);

	// Stage registers only look at these, never at the state itself
	modport stages (
		input fetch_kill, decode_hold, decode_kill,
		input execute_kill, tail_kill
	);

endinterface

//--- hw/pipe_sequencer.sv
// ==========================================================================
// Pipeline FSM with halt latch, PC operation choice and slot control decode.
// Hazard inputs only count when the fetch slot holds a real instruction.
// ==========================================================================
module pipe_sequencer
	import slurm_pipe_pkg::*;
(
	input  logic   CLK,
	input  logic   RSTb,
	input  logic   instruction_valid,	// Low on a fetch miss
	input  logic   fetch_bubble,	// Fetch slot holds a bubble
	input  logic   hazard_1,
	input  logic   hazard_2,
	input  logic   hazard_3,
	input  logic   branch,	// Load PC request from execute
	input  logic   halt_request,
	input  logic   wake,
	pipe_ctrl_if.seq ctrl,
	output pc_op_t pc_op,
	output logic   instruction_request
);

	pipe_state_t state;
	pipe_state_t state_next;
	logic        halt_lat;	// Sleep request waiting to be taken
	logic        can_stall;
	logic        in_stall;

	// A hazard on a bubble or under a branch never stalls
	assign can_stall = !fetch_bubble && !branch;
	assign in_stall  = (state == ST_STALL1) || (state == ST_STALL2) || (state == ST_STALL3);

	always_comb begin
		state_next = state;
		case (state)
			ST_RESET:  state_next = ST_EXEC;
			ST_EXEC: begin
				if (!instruction_valid)
					state_next = ST_ISTALL1;	// Miss beats everything
				else if (can_stall && hazard_1)
					state_next = ST_STALL1;
				else if (can_stall && hazard_2)
					state_next = ST_STALL2;
				else if (can_stall && hazard_3)
					state_next = ST_STALL3;
				else if (halt_lat)
					state_next = ST_HALT;
			end
			ST_STALL1:  state_next = ST_STALL2;
			ST_STALL2:  state_next = branch ? ST_EXEC : ST_STALL3;
			ST_STALL3:  state_next = ST_EXEC;
			ST_ISTALL1: state_next = ST_ISTALL2;	// PC rewinds here
			ST_ISTALL2: begin
				if (instruction_valid)
					state_next = ST_EXEC;
			end
			ST_HALT: begin
				if (wake)
					state_next = ST_EXEC;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			state <= ST_RESET;
		else
			state <= state_next;
	end

	// Latched sleep request, consumed once halt is reached
	always_ff @(posedge CLK) begin
		if (!RSTb)
			halt_lat <= 1'b0;
		else if (state == ST_HALT)
			halt_lat <= 1'b0;
		else if (halt_request)
			halt_lat <= 1'b1;
	end

	// PC operation per state, a branch always wins outside reset
	always_comb begin
		case (state)
			ST_RESET: pc_op = PC_CLEAR;
			ST_EXEC:  pc_op = branch ? PC_LOAD : PC_STEP;
			ST_STALL1, ST_STALL2, ST_STALL3, ST_ISTALL1:
				pc_op = branch ? PC_LOAD : PC_REWIND;	// Refetch the held word's successor
			default:  pc_op = branch ? PC_LOAD : PC_HOLD;	// ISTALL2 and HALT
		endcase
	end

	// Slot controls
	assign ctrl.fetch_kill   = (state != ST_EXEC) || branch;
	assign ctrl.decode_hold  = in_stall;
	assign ctrl.decode_kill  = (state == ST_RESET) || (state == ST_HALT) ||
	                           (state == ST_ISTALL1) || branch;	// Missed word is junk
	assign ctrl.execute_kill = (state == ST_RESET) || (state == ST_HALT) || in_stall;
	assign ctrl.tail_kill    = (state == ST_RESET);

	// Fetch port is released while sleeping
	assign instruction_request = (state != ST_HALT);

	a_state_legal: assert property (@(posedge CLK) disable iff (!RSTb)
		state inside {ST_RESET, ST_EXEC, ST_HALT, ST_STALL1, ST_STALL2,
		              ST_STALL3, ST_ISTALL1, ST_ISTALL2});

	// Held decode must never see a new fetched word behind it
	a_hold_kills_fetch: assert property (@(posedge CLK) disable iff (!RSTb)
		ctrl.decode_hold |-> ctrl.fetch_kill);

	a_halt_entry: assert property (@(posedge CLK) disable iff (!RSTb)
		$rose(state == ST_HALT) |-> $past(halt_lat));

endmodule

//--- hw/slurm_pipe_pkg.sv
// ==========================================================================
// Widths, vector types and enums for the pipeline controller.
// The word address is the byte address without its two low bits.
// ==========================================================================
package slurm_pipe_pkg;

	localparam int INSN_W      = 32;	// Instruction word
	localparam int ADDR_W      = 32;	// Byte address
	localparam int WORD_ADDR_W = 30;	// Word address, ADDR_W - 2
	localparam int REG_TAG_W   = 8;	// Destination register tag

	typedef logic [INSN_W-1:0]      insn_t;
	typedef logic [ADDR_W-1:0]      byte_addr_t;
	typedef logic [WORD_ADDR_W-1:0] word_addr_t;
	typedef logic [REG_TAG_W-1:0]   reg_tag_t;

	// Sequencer states
	typedef enum logic [2:0] {
		ST_RESET   = 3'd0,
		ST_EXEC    = 3'd1,
		ST_HALT    = 3'd2,	// Sleeping, no fetch requests
		ST_STALL1  = 3'd3,	// Hazard with slot 1, three cycle hold
		ST_STALL2  = 3'd4,
		ST_STALL3  = 3'd5,
		ST_ISTALL1 = 3'd6,	// Miss seen, PC rewinds
		ST_ISTALL2 = 3'd7	// Wait for instruction_valid
	} pipe_state_t;

	// Program counter operations
	typedef enum logic [2:0] {
		PC_CLEAR  = 3'd0,	// pc and prev to zero
		PC_HOLD   = 3'd1,
		PC_STEP   = 3'd2,	// prev takes pc, pc increments
		PC_LOAD   = 3'd3,	// prev takes pc, pc takes target
		PC_REWIND = 3'd4	// pc back to prev
	} pc_op_t;

endpackage

//--- hw/slurm_pipe_top.sv
// ==========================================================================
// Pipeline controller top level. The branch target is the upper 30 bits of
// load_pc_address; its two low bits are ignored.
// ==========================================================================
module slurm_pipe_top
	import slurm_pipe_pkg::*;
(
	input  logic       CLK,
	input  logic       RSTb,
	output logic       instruction_request,	// Low while halted
	input  logic       instruction_valid,
	output word_addr_t instruction_address,
	input  insn_t      instruction_in,
	input  word_addr_t instruction_address_in,
	output insn_t      pipeline_stage_0,
	output insn_t      pipeline_stage_1,
	output insn_t      pipeline_stage_2,
	output insn_t      pipeline_stage_3,
	output insn_t      pipeline_stage_4,
	output byte_addr_t pc_stage_4,
	output logic       nop_stage_2,
	output logic       nop_stage_4,
	input  logic       hazard_1,	// Fetch slot against slot 1
	input  logic       hazard_2,	// Fetch slot against slot 2
	input  logic       hazard_3,	// Fetch slot against slot 3
	input  reg_tag_t   hazard_reg0,
	input  logic       modifies_flags0,
	output reg_tag_t   hazard_reg1,
	output reg_tag_t   hazard_reg2,
	output reg_tag_t   hazard_reg3,
	output logic       modifies_flags1,
	output logic       modifies_flags2,
	output logic       modifies_flags3,
	input  logic       halt_request,
	input  logic       wake,
	input  logic       load_pc_request,
	input  byte_addr_t load_pc_address
);

	pipe_ctrl_if ctrl_if ();

	pc_op_t     pc_op;
	logic       fetch_bubble;
	word_addr_t target;

	assign target = load_pc_address[ADDR_W-1:2];

	pipe_sequencer seq_i (
		.CLK                 (CLK),
		.RSTb                (RSTb),
		.instruction_valid   (instruction_valid),
		.fetch_bubble        (fetch_bubble),
		.hazard_1            (hazard_1),
		.hazard_2            (hazard_2),
		.hazard_3            (hazard_3),
		.branch              (load_pc_request),
		.halt_request        (halt_request),
		.wake                (wake),
		.ctrl                (ctrl_if.seq),
		.pc_op               (pc_op),
		.instruction_request (instruction_request)
	);

	pc_unit pc_i (
		.CLK    (CLK),
		.pc_op  (pc_op),
		.target (target),
		.pc     (instruction_address)	// Fetch address is the live pc
	);

	stage_regs stages_i (
		.CLK                    (CLK),
		.ctrl                   (ctrl_if.stages),
		.instruction_in         (instruction_in),
		.instruction_address_in (instruction_address_in),
		.hazard_reg0            (hazard_reg0),
		.modifies_flags0        (modifies_flags0),
		.fetch_bubble           (fetch_bubble),
		.pipeline_stage_0       (pipeline_stage_0),
		.pipeline_stage_1       (pipeline_stage_1),
		.pipeline_stage_2       (pipeline_stage_2),
		.pipeline_stage_3       (pipeline_stage_3),
		.pipeline_stage_4       (pipeline_stage_4),
		.pc_stage_4             (pc_stage_4),
		.nop_stage_2            (nop_stage_2),
		.nop_stage_4            (nop_stage_4),
		.hazard_reg1            (hazard_reg1),
		.hazard_reg2            (hazard_reg2),
		.hazard_reg3            (hazard_reg3),
		.modifies_flags1        (modifies_flags1),
		.modifies_flags2        (modifies_flags2),
		.modifies_flags3        (modifies_flags3)
	);

endmodule

//--- hw/stage_regs.sv
// ==========================================================================
// Five pipeline slots with instruction, word PC and bubble bit. Hazard tags
// enter at decode and leave after the memory slot. No reset of their own.
// ==========================================================================
module stage_regs
	import slurm_pipe_pkg::*;
(
	input  logic       CLK,
	pipe_ctrl_if.stages ctrl,
	input  insn_t      instruction_in,
	input  word_addr_t instruction_address_in,
	input  reg_tag_t   hazard_reg0,	// Tag of the word now in fetch
	input  logic       modifies_flags0,
	output logic       fetch_bubble,
	output insn_t      pipeline_stage_0,
	output insn_t      pipeline_stage_1,
	output insn_t      pipeline_stage_2,
	output insn_t      pipeline_stage_3,
	output insn_t      pipeline_stage_4,
	output byte_addr_t pc_stage_4,
	output logic       nop_stage_2,	// Execute must not change state
	output logic       nop_stage_4,	// No writeback
	output reg_tag_t   hazard_reg1,
	output reg_tag_t   hazard_reg2,
	output reg_tag_t   hazard_reg3,
	output logic       modifies_flags1,
	output logic       modifies_flags2,
	output logic       modifies_flags3
);

	word_addr_t pc_s0, pc_s1, pc_s2, pc_s3, pc_s4;
	logic       nop_s1, nop_s3;

	// Fetch slot
	always_ff @(posedge CLK) begin
		pipeline_stage_0 <= instruction_in;
		pc_s0            <= instruction_address_in;
		fetch_bubble     <= ctrl.fetch_kill;
	end

	// Decode slot, frozen during a hazard stall
	always_ff @(posedge CLK) begin
		if (!ctrl.decode_hold) begin
			pipeline_stage_1 <= pipeline_stage_0;
			pc_s1            <= pc_s0;
			hazard_reg1      <= hazard_reg0;
			modifies_flags1  <= modifies_flags0;
		end
		if (ctrl.decode_kill)
			nop_s1 <= 1'b1;
		else if (!ctrl.decode_hold)
			nop_s1 <= fetch_bubble;	// Held slot keeps its old bubble bit
	end

	// Execute slot
	always_ff @(posedge CLK) begin
		pipeline_stage_2 <= pipeline_stage_1;
		pc_s2            <= pc_s1;
		hazard_reg2      <= hazard_reg1;
		modifies_flags2  <= modifies_flags1;
		nop_stage_2      <= ctrl.execute_kill || nop_s1;
	end

	// Memory slot, last one with hazard tags
	always_ff @(posedge CLK) begin
		pipeline_stage_3 <= pipeline_stage_2;
		pc_s3            <= pc_s2;
		hazard_reg3      <= hazard_reg2;
		modifies_flags3  <= modifies_flags2;
		nop_s3           <= ctrl.tail_kill || nop_stage_2;
	end

	// Writeback slot
	always_ff @(posedge CLK) begin
		pipeline_stage_4 <= pipeline_stage_3;
		pc_s4            <= pc_s3;
		nop_stage_4      <= ctrl.tail_kill || nop_s3;
	end

	assign pc_stage_4 = {pc_s4, 2'b00};	// Back to a byte address

	// A held decode word must not also be copied into execute
	a_hold_bubbles_exec: assert property (@(posedge CLK)
		ctrl.decode_hold |-> ctrl.execute_kill);

endmodule

//--- slurm_pipe_top.f
hw/slurm_pipe_pkg.sv
hw/pipe_ctrl_if.sv
hw/pipe_sequencer.sv
hw/pc_unit.sv
hw/stage_regs.sv
hw/slurm_pipe_top.sv
dv/tb_slurm_pipe.sv
